// File: Makefile
# Verilator flow for the branch and compare unit.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= cmp_unit_tb
FILELIST   ?= cmp_unit_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cmp_unit_top.f
+incdir+src
src/cmp_pkg.sv
src/cmp_rs.sv
src/branch_resolve.sv
src/cmp_unit_top.sv
test/cmp_unit_assert.sv
test/cmp_unit_tb.sv

// File: src/branch_resolve.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmp_params.svh"

module branch_resolve (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                flush,
    input  wire logic                iss_valid,
    input  wire cmp_pkg::cmp_issue_t iss,
    output logic                     iss_ready,
    output logic                     res_valid,
    output cmp_pkg::cmp_result_t     res,
    input  wire logic                res_ready
);

    import cmp_pkg::*;

    localparam int XLEN = `CMP_XLEN;

    logic        taken;
    cmp_result_t res_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (iss.op)
            beq:     taken = (iss.vj == iss.vk);
            bne:     taken = (iss.vj != iss.vk);
            blt:     taken = ($signed(iss.vj) < $signed(iss.vk));
            bge:     taken = ($signed(iss.vj) >= $signed(iss.vk));
            bltu:    taken = (iss.vj < iss.vk);
            bgeu:    taken = (iss.vj >= iss.vk);
            default: taken = 1'b0; // unused funct3 codes.
        endcase
    end

    always_comb begin
        res_d.tag   = iss.dest;
        res_d.is_br = iss.is_br;
        if (iss.is_br) begin
            res_d.value      = '0;
            res_d.pc_next    = taken ? (iss.pc + iss.b_imm) : (iss.pc + XLEN'(4));
            res_d.mispredict = (iss.br_pred != taken);
        end else begin
            res_d.value      = XLEN'(taken); // slt/sltu write 0 or 1.
            res_d.pc_next    = '0;
            res_d.mispredict = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign iss_ready = !res_valid || res_ready; // empty or draining now.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (flush) begin
            res_valid <= 1'b0;
        end else if (iss_valid && iss_ready) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            res <= res_d; // held while cdb stalls.
        end
    end

endmodule

`default_nettype wire

// File: src/cmp_params.svh
`ifndef CMP_PARAMS_SVH
`define CMP_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CMP_XLEN 32 // operand and pc width.
`define CMP_TAG_W 3 // rob tag, zero means value present.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// station sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CMP_RS_DEPTH 3 // entries in the comparator station.

`endif

// File: src/cmp_pkg.sv
`default_nettype none

`include "cmp_params.svh"

package cmp_pkg;

    typedef logic [`CMP_XLEN-1:0] cmp_word_t;
    typedef logic [`CMP_TAG_W-1:0] cmp_tag_t;

    // compare ops in branch funct3 encoding.
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic      is_br;   // clear for slt/sltu.
        cmp_op_t   op;
        cmp_word_t vj;
        cmp_word_t vk;
        cmp_tag_t  qj;      // producer of vj, zero when present.
        cmp_tag_t  qk;
        cmp_tag_t  dest;
        logic      br_pred; // predicted taken.
        cmp_word_t pc;
        cmp_word_t b_imm;
    } cmp_dispatch_t;

    typedef struct packed {
        logic      valid;
        cmp_tag_t  tag;
        cmp_word_t value;
    } cmp_wakeup_t;

    typedef struct packed {
        logic      is_br;
        cmp_op_t   op;
        cmp_word_t vj;
        cmp_word_t vk;
        cmp_tag_t  dest;
        logic      br_pred;
        cmp_word_t pc;
        cmp_word_t b_imm;
    } cmp_issue_t;

    typedef struct packed {
        cmp_tag_t  tag;
        cmp_word_t value;      // 0/1 for slt forms.
        cmp_word_t pc_next;
        logic      mispredict;
        logic      is_br;
    } cmp_result_t;

endpackage

`default_nettype wire

// File: src/cmp_rs.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmp_params.svh"

module cmp_rs (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   flush,
    input  wire logic                   disp_valid,
    input  wire cmp_pkg::cmp_dispatch_t disp,
    output logic                        disp_ready,
    input  wire cmp_pkg::cmp_wakeup_t   wakeup,
    output logic                        iss_valid,
    output cmp_pkg::cmp_issue_t         iss,
    input  wire logic                   iss_ready
);

    import cmp_pkg::*;

    localparam int DEPTH = `CMP_RS_DEPTH;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cmp_dispatch_t    ent [DEPTH]; // payload plus pending tags.
    logic [DEPTH-1:0] busy;

    logic [DEPTH-1:0] rdy;         // busy with both operands present.
    logic [DEPTH-1:0] hit_j;
    logic [DEPTH-1:0] hit_k;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] iss_idx;
    cmp_dispatch_t    disp_fwd;    // dispatch payload after same-edge wakeup.
    logic             disp_fire;
    logic             iss_fire;
    logic             wk_live;

    assign wk_live   = wakeup.valid && (wakeup.tag != '0);
    assign disp_fire = disp_valid && disp_ready;
    assign iss_fire  = iss_valid && iss_ready;

    // incoming op grabs a broadcast on the edge it lands.
    always_comb begin
        disp_fwd = disp;
        if (wk_live && disp.qj == wakeup.tag) begin
            disp_fwd.vj = wakeup.value;
            disp_fwd.qj = '0;
        end
        if (wk_live && disp.qk == wakeup.tag) begin
            disp_fwd.vk = wakeup.value;
            disp_fwd.qk = '0;
        end
    end

    // per-entry tag snoop and readiness.
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit_j[i] = wk_live && (ent[i].qj == wakeup.tag);
            hit_k[i] = wk_live && (ent[i].qk == wakeup.tag);
            rdy[i]   = busy[i] && (ent[i].qj == '0) && (ent[i].qk == '0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocate and select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        free_idx   = '0;
        disp_ready = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx   = IDX_W'(i); // lowest free slot wins.
                disp_ready = 1'b1;
            end
        end
    end

    always_comb begin
        iss_idx   = '0;
        iss_valid = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (rdy[i]) begin
                iss_idx   = IDX_W'(i); // lowest ready entry.
                iss_valid = 1'b1;
            end
        end
    end

    always_comb begin
        iss.is_br   = ent[iss_idx].is_br;
        iss.op      = ent[iss_idx].op;
        iss.vj      = ent[iss_idx].vj;
        iss.vk      = ent[iss_idx].vk;
        iss.dest    = ent[iss_idx].dest;
        iss.br_pred = ent[iss_idx].br_pred;
        iss.pc      = ent[iss_idx].pc;
        iss.b_imm   = ent[iss_idx].b_imm;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a slot freed by issue is still busy for allocation this cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0; // drop all waiting work.
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (iss_fire && iss_idx == IDX_W'(i)) begin
                    busy[i] <= 1'b0;
                end else if (disp_fire && free_idx == IDX_W'(i)) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (disp_fire && free_idx == IDX_W'(i)) begin
                ent[i] <= disp_fwd;
            end else begin
                if (hit_j[i]) begin
                    ent[i].vj <= wakeup.value;
                    ent[i].qj <= '0;
                end
                if (hit_k[i]) begin
                    ent[i].vk <= wakeup.value;
                    ent[i].qk <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cmp_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module cmp_unit_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   flush,
    input  wire logic                   disp_valid,
    input  wire cmp_pkg::cmp_dispatch_t disp,
    output logic                        disp_ready,
    input  wire cmp_pkg::cmp_wakeup_t   wakeup,
    output logic                        res_valid,
    output cmp_pkg::cmp_result_t        res,
    input  wire logic                   res_ready
);

    import cmp_pkg::*;

    // station to resolve stage.
    logic       iss_valid;
    logic       iss_ready;
    cmp_issue_t iss;

    cmp_rs u_rs (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_ready (disp_ready),
        .wakeup     (wakeup),
        .iss_valid  (iss_valid),
        .iss        (iss),
        .iss_ready  (iss_ready)
    );

    branch_resolve u_resolve (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss       (iss),
        .iss_ready (iss_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

// File: test/cmp_unit_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cmp_unit_assert (
    input wire logic                 clk,
    input wire logic                 arst_n,
    input wire logic                 flush,
    input wire logic                 disp_ready,
    input wire logic                 res_valid,
    input wire cmp_pkg::cmp_result_t res,
    input wire logic                 res_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result port handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_res_hold: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready && !flush |=> res_valid && $stable(res))
        else $error("result changed while the bus stalled");

    a_flush_clr: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !res_valid)
        else $error("result still valid after flush");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset behavior
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checked one edge on, once the reset has landed.
    a_rst_idle: assert property (@(posedge clk) !arst_n |=> !res_valid)
        else $error("result valid during reset");

    a_rst_ready: assert property (@(posedge clk) $rose(arst_n) |-> disp_ready)
        else $error("no free slot right after reset");

endmodule

bind cmp_unit_top cmp_unit_assert u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .disp_ready (disp_ready),
    .res_valid  (res_valid),
    .res        (res),
    .res_ready  (res_ready)
);

`default_nettype wire

// File: test/cmp_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cmp_params.svh"

module cmp_unit_tb;

    import cmp_pkg::*;

    localparam int NTAG  = 1 << `CMP_TAG_W;
    localparam int DEPTH = `CMP_RS_DEPTH;
    localparam int TMO   = 200; // cycles allowed per wait.

    logic          clk = 1'b0;
    logic          arst_n;
    logic          flush;
    logic          disp_valid;
    cmp_dispatch_t disp;
    logic          disp_ready;
    cmp_wakeup_t   wakeup;
    logic          res_valid;
    cmp_result_t   res;
    logic          res_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard state, indexed by tag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cmp_result_t exp_tab   [NTAG];
    logic        exp_valid [NTAG];
    cmp_tag_t    wait_j    [NTAG]; // wakeups still owed.
    cmp_tag_t    wait_k    [NTAG];
    cmp_word_t   final_vj  [NTAG]; // operand after all wakeups.
    cmp_word_t   final_vk  [NTAG];
    cmp_word_t   pval      [NTAG]; // broadcast value per producer.
    cmp_op_t     ops [6] = '{beq, bne, blt, bge, bltu, bgeu};
    int          in_flight = 0;
    int          n_pass = 0;
    int          n_err = 0;
    int          seed = 42334;
    logic        aborted = 1'b0; // set once a wait has run out.

    always #2 clk = ~clk;

    cmp_unit_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_ready (disp_ready),
        .wakeup     (wakeup),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready)
    );

    function automatic cmp_result_t cmp_expect(input cmp_dispatch_t d);
        cmp_result_t r;
        logic        eq;
        logic        lt_u;
        logic        lt_s;
        logic        tk;
        eq   = (d.vj == d.vk);
        lt_u = (d.vj < d.vk);
        // differing sign bits settle a signed compare alone.
        lt_s = (d.vj[`CMP_XLEN-1] != d.vk[`CMP_XLEN-1]) ? d.vj[`CMP_XLEN-1] : lt_u;
        case (d.op)
            beq:     tk = eq;
            bne:     tk = !eq;
            blt:     tk = lt_s;
            bge:     tk = !lt_s;
            bltu:    tk = lt_u;
            bgeu:    tk = !lt_u;
            default: tk = 1'b0;
        endcase
        r.tag        = d.dest;
        r.is_br      = d.is_br;
        r.value      = d.is_br ? '0 : cmp_word_t'(tk);
        r.pc_next    = !d.is_br ? '0 : (tk ? d.pc + d.b_imm : d.pc + 32'd4);
        r.mispredict = d.is_br && (d.br_pred != tk);
        return r;
    endfunction

    function automatic cmp_word_t rnd();
        return $random(seed);
    endfunction

    // corner operands for the compares.
    function automatic cmp_word_t edge_val();
        cmp_word_t r;
        r = rnd();
        case (r[2:0])
            3'd0:    r = 32'h0000_0000;
            3'd1:    r = 32'h0000_0001;
            3'd2:    r = 32'hffff_ffff;
            3'd3:    r = 32'h8000_0000;
            3'd4:    r = 32'h7fff_ffff;
            default: r = rnd();
        endcase
        return r;
    endfunction

    function automatic cmp_dispatch_t rand_branch(input cmp_op_t op, input cmp_tag_t dest);
        cmp_dispatch_t d;
        cmp_word_t     r;
        r         = rnd();
        d         = '0;
        d.is_br   = 1'b1;
        d.op      = op;
        d.dest    = dest;
        d.vj      = rnd();
        d.vk      = r[0] ? d.vj : rnd(); // equal operands now and then.
        d.br_pred = r[1];
        d.pc      = rnd() & 32'hffff_fffc;
        d.b_imm   = {{19{r[12]}}, r[12:1], 1'b0};
        return d;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        aborted = 1'b1;
    endtask

    task automatic check_result(input cmp_result_t r);
        cmp_result_t e;
        e = exp_tab[r.tag];
        if (!exp_valid[r.tag]) begin
            n_err++;
            $display("[ERROR] %0t: unexpected or repeated tag %0d", $time, r.tag);
        end else if (wait_j[r.tag] != '0 || wait_k[r.tag] != '0) begin
            n_err++;
            $display("[ERROR] %0t: tag %0d resolved before its wakeup", $time, r.tag);
        end else if (r != e) begin
            n_err++;
            $display("[ERROR] %0t: tag %0d got %h %h %b, expected %h %h %b", $time, r.tag,
                     r.value, r.pc_next, r.mispredict, e.value, e.pc_next, e.mispredict);
        end else begin
            n_pass++;
        end
        if (exp_valid[r.tag]) begin
            in_flight--;
        end
        exp_valid[r.tag] = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor on the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        cmp_dispatch_t fin;
        if (arst_n) begin
            if (res_valid && res_ready) begin
                check_result(res);
            end
            if (disp_valid && disp_ready) begin
                fin    = disp;
                fin.vj = final_vj[disp.dest];
                fin.vk = final_vk[disp.dest];
                exp_tab[disp.dest]   = cmp_expect(fin);
                exp_valid[disp.dest] = 1'b1;
                wait_j[disp.dest]    = disp.qj;
                wait_k[disp.dest]    = disp.qk;
                in_flight++;
            end
            if (wakeup.valid && wakeup.tag != '0) begin
                for (int t = 0; t < NTAG; t++) begin
                    if (wait_j[t] == wakeup.tag) begin
                        wait_j[t] = '0;
                    end
                    if (wait_k[t] == wakeup.tag) begin
                        wait_k[t] = '0;
                    end
                end
            end
            if (flush) begin
                for (int t = 0; t < NTAG; t++) begin
                    exp_valid[t] = 1'b0; // flushed tags must never show up.
                end
                in_flight = 0;
            end
        end
    end

    // called on a falling edge, returns on a falling edge.
    task automatic send(input cmp_dispatch_t d, input cmp_word_t fvj, input cmp_word_t fvk);
        int t;
        if (aborted) begin
            return;
        end
        t = 0;
        while (exp_valid[d.dest] && t < TMO) begin
            @(negedge clk);
            t++;
        end
        if (exp_valid[d.dest]) begin
            abort_run("dest tag never came back");
            return;
        end
        final_vj[d.dest] = fvj;
        final_vk[d.dest] = fvk;
        disp       = d;
        disp_valid = 1'b1;
        t = 0;
        while (!disp_ready && t < TMO) begin
            @(negedge clk);
            t++;
        end
        if (!disp_ready) begin
            abort_run("dispatch was never accepted");
            disp_valid = 1'b0;
            return;
        end
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic broadcast(input cmp_tag_t tag, input cmp_word_t value);
        wakeup.valid = 1'b1;
        wakeup.tag   = tag;
        wakeup.value = value;
        @(negedge clk);
        wakeup = '0;
    endtask

    task automatic wait_drain();
        int t;
        if (aborted) begin
            return;
        end
        t = 0;
        while (in_flight != 0 && t < TMO) begin
            @(negedge clk);
            t++;
        end
        if (in_flight != 0) begin
            abort_run("result never appeared");
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (aborted) begin
            $display("test %s: timed out", name);
        end else if (n_err == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_err - err0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        cmp_dispatch_t d;
        cmp_result_t   snap;
        cmp_word_t     r;
        int            err0;
        for (int t = 0; t < NTAG; t++) begin
            exp_valid[t] = 1'b0;
            wait_j[t]    = '0;
            wait_k[t]    = '0;
        end
        arst_n     = 1'b0;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp       = '0;
        wakeup     = '0;
        res_ready  = 1'b1;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        err0 = n_err;
        for (int i = 0; i < 16; i++) begin
            d      = '0;
            d.op   = i[0] ? bltu : blt; // slt and sltu forms.
            d.vj   = edge_val();
            d.vk   = edge_val();
            d.dest = cmp_tag_t'(1 + i % 7);
            send(d, d.vj, d.vk);
        end
        wait_drain();
        report_test("set-less-than", err0);

        err0 = n_err;
        for (int i = 0; i < 24; i++) begin
            d = rand_branch(ops[i % 6], cmp_tag_t'(1 + i % 7));
            send(d, d.vj, d.vk);
        end
        wait_drain();
        report_test("branch resolution", err0);

        // dests 1..3 wait on producers 4..7.
        err0 = n_err;
        for (int n = 0; n < 4; n++) begin
            for (int p = 4; p < NTAG; p++) begin
                pval[p] = rnd();
            end
            for (int i = 0; i < DEPTH; i++) begin
                r = rnd();
                d = rand_branch(ops[r[10:8] % 6], cmp_tag_t'(1 + i));
                if (r[7]) begin
                    d.is_br = 1'b0;
                    d.op    = r[6] ? blt : bltu;
                end
                d.qj = r[0] ? cmp_tag_t'(4 + r[2:1]) : '0;
                d.qk = r[3] ? cmp_tag_t'(4 + r[5:4]) : '0;
                if (d.qj == '0 && d.qk == '0) begin
                    d.qk = cmp_tag_t'(7);
                end
                send(d, (d.qj != '0) ? pval[d.qj] : d.vj, (d.qk != '0) ? pval[d.qk] : d.vk);
            end
            for (int p = 4; p < NTAG; p++) begin
                repeat (rnd() & 3) @(negedge clk);
                broadcast(cmp_tag_t'(p), pval[p]);
            end
            wait_drain();
        end
        // wakeup lands on the dispatch edge itself.
        pval[5] = rnd();
        d       = rand_branch(bne, cmp_tag_t'(1));
        d.qj    = cmp_tag_t'(5);
        wakeup.valid = 1'b1;
        wakeup.tag   = cmp_tag_t'(5);
        wakeup.value = pval[5];
        send(d, pval[5], d.vk);
        wakeup = '0;
        wait_drain();
        report_test("operand wakeup", err0);

        err0      = n_err;
        res_ready = 1'b0;
        for (int i = 0; i <= DEPTH; i++) begin
            d = rand_branch(ops[i % 6], cmp_tag_t'(1 + i));
            send(d, d.vj, d.vk);
        end
        if (disp_ready || !res_valid || in_flight != DEPTH + 1) begin
            n_err++;
            $display("[ERROR] %0t: station not full under back-pressure", $time);
        end
        snap = res;
        repeat (6) @(negedge clk);
        if (!res_valid || res != snap) begin
            n_err++;
            $display("[ERROR] %0t: held result changed", $time);
        end
        res_ready = 1'b1;
        wait_drain();
        report_test("back-pressure", err0);

        // one result held in the register, the station full of waiting work.
        err0      = n_err;
        res_ready = 1'b0;
        d = rand_branch(bge, cmp_tag_t'(7));
        send(d, d.vj, d.vk);
        for (int i = 0; i < DEPTH; i++) begin
            d    = rand_branch(ops[i % 6], cmp_tag_t'(1 + i));
            d.qj = cmp_tag_t'(4 + i);
            send(d, d.vj, d.vk);
        end
        if (disp_ready || !res_valid) begin
            n_err++;
            $display("[ERROR] %0t: station should be full before flush", $time);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (res_valid || !disp_ready) begin
            n_err++;
            $display("[ERROR] %0t: unit not idle after flush", $time);
        end
        res_ready = 1'b1;
        for (int p = 4; p < 4 + DEPTH; p++) begin
            broadcast(cmp_tag_t'(p), rnd());
        end
        repeat (10) @(negedge clk);
        d = rand_branch(beq, cmp_tag_t'(5)); // unit still works afterwards.
        send(d, d.vj, d.vk);
        wait_drain();
        report_test("flush", err0);

        $display("checks passed: %0d, errors: %0d", n_pass, n_err);
        if (n_err == 0 && n_pass > 0 && !aborted) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
